// ==== Makefile ====
# Verilator lint and simulation of the arcade input section

VERILATOR  ?= verilator
TOP        ?= arcade_inputs_tb
FILELIST   ?= arcade_inputs.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
LINT_FLAGS ?= --timing
VFLAGS     ?= --timing -Wno-fatal
PASS_MSG   ?= Done: no errors

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

# the log decides pass or fail
sim: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== arcade_inputs.f ====
verilog/arcade_inputs_pkg.sv
verilog/joy_4way.sv
verilog/joy_player.sv
verilog/board_ctrl.sv
verilog/game_reset.sv
verilog/arcade_inputs.sv
sim/tb_clkgen.sv
sim/arcade_inputs_tb.sv

// ==== sim/arcade_inputs_tb.sv ====
// ----------------------------------------------------------------------
// arcade input section testbench
// directed tests of the joystick paths, control keys and game reset
// ----------------------------------------------------------------------
module arcade_inputs_tb;
    import arcade_inputs_pkg::*;

    // same values as the DUT defaults
    localparam int BUTTONS    = 2;
    localparam bit ACTIVE_LOW = 1'b1;
    localparam int RST_HOLD   = 16;
    localparam int START_BIT  = BUTTONS + 4;
    localparam int COIN_BIT   = BUTTONS + 5;
    localparam int PAUSE_BIT  = BUTTONS + 6;
    localparam int ROUNDS     = 8;
    // reset, joystick, rotation, coin, pause and soft reset tests plus margin
    localparam int RUN_CYCLES = 10 + (ROUNDS * 3 + 12) + 24 + ROUNDS * 2 + 16
                                + (2 * RST_HOLD + 16) + 50;

    logic         clk_sys;
    logic         rst;
    logic         en_4way;
    logic         rotate;
    logic         flip;
    board_joy_t   board_joys [PLAYERS];
    game_joy_t    key_joys [PLAYERS];
    game_joy_t    game_joys [PLAYERS];
    player_bits_t key_start;
    player_bits_t key_coin;
    logic         key_pause;
    logic         key_reset;
    logic         key_service;
    gfx_en_t      key_gfx;
    logic         osd_pause;
    logic         downloading;
    logic         rst_req;
    player_bits_t game_coin;
    player_bits_t game_start;
    logic         game_service;
    logic         game_pause;
    gfx_en_t      gfx_en;
    logic         game_rst;
    logic [31:0]  lfsr;

    tb_clkgen #(.PERIOD(8), .RST_CYCLES(10)) i_clkgen (.clk_sys(clk_sys), .rst(rst));

    arcade_inputs i_dut (
        .clk_sys(clk_sys), .rst(rst), .en_4way(en_4way), .rotate(rotate), .flip(flip),
        .board_joystick1(board_joys[0]), .board_joystick2(board_joys[1]),
        .board_joystick3(board_joys[2]), .board_joystick4(board_joys[3]),
        .key_joy1(key_joys[0]), .key_joy2(key_joys[1]),
        .key_joy3(key_joys[2]), .key_joy4(key_joys[3]),
        .key_start(key_start), .key_coin(key_coin), .key_pause(key_pause),
        .key_reset(key_reset), .key_service(key_service), .key_gfx(key_gfx),
        .osd_pause(osd_pause), .downloading(downloading), .rst_req(rst_req),
        .game_joystick1(game_joys[0]), .game_joystick2(game_joys[1]),
        .game_joystick3(game_joys[2]), .game_joystick4(game_joys[3]),
        .game_coin(game_coin), .game_start(game_start), .game_service(game_service),
        .game_pause(game_pause), .gfx_en(gfx_en), .game_rst(game_rst)
    );

    // 32-bit Fibonacci LFSR with taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic draw_bits(input int nbits, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < nbits; i++) begin
            lfsr  = lfsr_step(lfsr);
            value = {value[30:0], lfsr[0]};
        end
    endtask

    // game word from board and keyboard levels with the rotation table applied
    function automatic game_joy_t expect_joy(board_joy_t b, game_joy_t k, logic rot,
                                             logic flp);
        game_joy_t m;
        dir_t      d;
        m = b[GAME_JW-1:0] | k;
        d = m[3:0];
        if (rot && !flp) begin
            m[3:0] = {d[0], d[1], d[3], d[2]};
        end else if (rot) begin
            m[3:0] = {d[1], d[0], d[2], d[3]};
        end
        return ACTIVE_LOW ? ~m : m;
    endfunction

    task automatic stop_on_error(input string what);
        $display("%s", what);
        $display("Done: errors found");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_joy(input string name, input game_joy_t got, input game_joy_t exp);
        if (got !== exp) begin
            stop_on_error($sformatf("FAIL %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_players(input string name, input player_bits_t got,
                                 input player_bits_t exp);
        if (got !== exp) begin
            stop_on_error($sformatf("FAIL %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_gfx(input string name, input gfx_en_t got, input gfx_en_t exp);
        if (got !== exp) begin
            stop_on_error($sformatf("FAIL %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            stop_on_error($sformatf("FAIL %s got %h expected %h", name, got, exp));
        end
    endtask

    // inputs change one time unit after the rising edge
    task automatic next_cycle(input int n = 1);
        repeat (n) @(posedge clk_sys);
        #1;
    endtask

    task automatic drive_idle();
        en_4way     = 1'b0;
        rotate      = 1'b0;
        flip        = 1'b0;
        key_start   = '0;
        key_coin    = '0;
        key_pause   = 1'b0;
        key_reset   = 1'b0;
        key_service = 1'b0;
        key_gfx     = '0;
        osd_pause   = 1'b0;
        downloading = 1'b0;
        rst_req     = 1'b0;
        for (int p = 0; p < PLAYERS; p++) begin
            board_joys[p] = '0;
            key_joys[p]   = '0;
        end
    endtask

    task automatic check_all_joys();
        for (int p = 0; p < PLAYERS; p++) begin
            check_joy($sformatf("game_joystick%0d", p + 1), game_joys[p],
                      expect_joy(board_joys[p], key_joys[p], rotate, flip));
        end
    endtask

    task automatic test_reset_state();
        check_all_joys();
        check_players("game_coin", game_coin, {PLAYERS{ACTIVE_LOW}});
        check_players("game_start", game_start, {PLAYERS{ACTIVE_LOW}});
        check_bit("game_service", game_service, ACTIVE_LOW);
        check_bit("game_pause", game_pause, 1'b0);
        check_gfx("gfx_en", gfx_en, '1);
        check_bit("game_rst", game_rst, 1'b1);
    endtask

    task automatic test_joystick_path();
        logic [31:0] r;
        for (int n = 0; n < ROUNDS; n++) begin
            for (int p = 0; p < PLAYERS; p++) begin
                draw_bits(JOY_BW, r);
                board_joys[p] = r[JOY_BW-1:0];
                draw_bits(GAME_JW, r);
                key_joys[p] = r[GAME_JW-1:0];
            end
            next_cycle(3);
            check_all_joys();
        end
        // 4-way filter on player 1 only
        drive_idle();
        en_4way = 1'b1;
        board_joys[0] = 16'h0001;
        next_cycle(3);
        check_joy("game_joystick1", game_joys[0], expect_joy(16'h0001, '0, 1'b0, 1'b0));
        // up added on top of right is ignored
        board_joys[0] = 16'h0009;
        next_cycle(3);
        check_joy("game_joystick1", game_joys[0], expect_joy(16'h0001, '0, 1'b0, 1'b0));
        board_joys[0] = '0;
        next_cycle(3);
        board_joys[0] = 16'h000a;
        next_cycle(3);
        check_joy("game_joystick1", game_joys[0], expect_joy('0, '0, 1'b0, 1'b0));
        drive_idle();
    endtask

    task automatic test_rotation();
        rotate = 1'b1;
        for (int f = 0; f < 2; f++) begin
            for (int d = 0; d < 4; d++) begin
                flip          = (f == 1);
                board_joys[0] = board_joy_t'(1 << d);
                key_joys[1]   = game_joy_t'(1 << d);
                next_cycle(3);
                check_all_joys();
            end
        end
        drive_idle();
    endtask

    task automatic test_coin_start();
        logic [31:0]  r;
        player_bits_t jc;
        player_bits_t js;
        for (int n = 0; n < ROUNDS; n++) begin
            draw_bits(PLAYERS, r);
            jc = r[PLAYERS-1:0];
            draw_bits(PLAYERS, r);
            js = r[PLAYERS-1:0];
            draw_bits(PLAYERS, r);
            key_coin = r[PLAYERS-1:0];
            draw_bits(PLAYERS, r);
            key_start = r[PLAYERS-1:0];
            draw_bits(1, r);
            key_service = r[0];
            for (int p = 0; p < PLAYERS; p++) begin
                board_joys[p]            = '0;
                board_joys[p][COIN_BIT]  = jc[p];
                board_joys[p][START_BIT] = js[p];
            end
            next_cycle(2);
            check_players("game_coin", game_coin, (jc | key_coin) ^ {PLAYERS{ACTIVE_LOW}});
            check_players("game_start", game_start, (js | key_start) ^ {PLAYERS{ACTIVE_LOW}});
            check_bit("game_service", game_service, key_service ^ ACTIVE_LOW);
        end
        drive_idle();
    endtask

    task automatic test_pause();
        next_cycle(3);
        // a download clears pause to start from a known state
        downloading = 1'b1;
        next_cycle();
        downloading = 1'b0;
        check_bit("game_pause", game_pause, 1'b0);
        key_pause = 1'b1;
        next_cycle();
        key_pause = 1'b0;
        check_bit("game_pause", game_pause, 1'b1);
        // player 2 pause button goes through the sync stage first
        board_joys[1][PAUSE_BIT] = 1'b1;
        next_cycle(2);
        board_joys[1][PAUSE_BIT] = 1'b0;
        check_bit("game_pause", game_pause, 1'b0);
        next_cycle(2);
        check_bit("game_pause", game_pause, 1'b0);
        osd_pause = 1'b1;
        next_cycle();
        check_bit("game_pause", game_pause, 1'b1);
        downloading = 1'b1;
        next_cycle();
        check_bit("game_pause", game_pause, 1'b0);
        downloading = 1'b0;
        osd_pause   = 1'b0;
        next_cycle();
        check_bit("game_pause", game_pause, 1'b0);
    endtask

    task automatic test_soft_reset_gfx();
        next_cycle(RST_HOLD + 4);
        check_bit("game_rst", game_rst, 1'b0);
        key_reset = 1'b1;
        next_cycle();
        key_reset = 1'b0;
        check_bit("game_rst", game_rst, 1'b1);
        next_cycle(RST_HOLD - 2);
        check_bit("game_rst", game_rst, 1'b1);
        next_cycle(6);
        check_bit("game_rst", game_rst, 1'b0);
        // layer 2 off, then back on
        key_gfx = 4'b0100;
        next_cycle();
        key_gfx = '0;
        check_gfx("gfx_en", gfx_en, 4'b1011);
        next_cycle();
        key_gfx = 4'b0100;
        next_cycle();
        key_gfx = '0;
        check_gfx("gfx_en", gfx_en, 4'b1111);
    endtask

    initial begin
        lfsr = 32'h4fe6;
        drive_idle();
        @(negedge rst);
        test_reset_state();
        test_joystick_path();
        test_rotation();
        test_coin_start();
        test_pause();
        test_soft_reset_gfx();
        $display("Done: no errors");
        $finish;
    end

    // watchdog
    initial begin
        repeat (RUN_CYCLES) @(posedge clk_sys);
        stop_on_error("timeout, the tests did not finish in time");
    end

endmodule

// ==== sim/tb_clkgen.sv ====
// ----------------------------------------------------------------------
// testbench clock and reset generator
// free running clock, reset held high for a fixed number of cycles
// ----------------------------------------------------------------------
module tb_clkgen #(
    parameter int PERIOD     = 8,
    parameter int RST_CYCLES = 10
) (
    output logic clk_sys,
    output logic rst
);

    initial begin
        clk_sys = 1'b0;
        forever #(PERIOD / 2) clk_sys = ~clk_sys;
    end

    // release one time unit after the edge, like all other inputs
    initial begin
        rst = 1'b1;
        repeat (RST_CYCLES) @(posedge clk_sys);
        #1;
        rst = 1'b0;
    end

endmodule

// ==== verilog/arcade_inputs.sv ====
// ----------------------------------------------------------------------
// arcade input section top level
// four player joystick paths, board control keys and game reset
// ----------------------------------------------------------------------
module arcade_inputs #(
    parameter int BUTTONS    = 2,
    parameter bit ACTIVE_LOW = 1'b1,
    parameter int RST_HOLD   = 16
) (
    input  logic                            clk_sys,
    input  logic                            rst,
    input  logic                            en_4way,
    input  logic                            rotate,
    input  logic                            flip,
    input  arcade_inputs_pkg::board_joy_t   board_joystick1,
    input  arcade_inputs_pkg::board_joy_t   board_joystick2,
    input  arcade_inputs_pkg::board_joy_t   board_joystick3,
    input  arcade_inputs_pkg::board_joy_t   board_joystick4,
    input  arcade_inputs_pkg::game_joy_t    key_joy1,
    input  arcade_inputs_pkg::game_joy_t    key_joy2,
    input  arcade_inputs_pkg::game_joy_t    key_joy3,
    input  arcade_inputs_pkg::game_joy_t    key_joy4,
    input  arcade_inputs_pkg::player_bits_t key_start,
    input  arcade_inputs_pkg::player_bits_t key_coin,
    input  logic                            key_pause,
    input  logic                            key_reset,
    input  logic                            key_service,
    input  arcade_inputs_pkg::gfx_en_t      key_gfx,
    input  logic                            osd_pause,
    input  logic                            downloading,
    input  logic                            rst_req,
    output arcade_inputs_pkg::game_joy_t    game_joystick1,
    output arcade_inputs_pkg::game_joy_t    game_joystick2,
    output arcade_inputs_pkg::game_joy_t    game_joystick3,
    output arcade_inputs_pkg::game_joy_t    game_joystick4,
    output arcade_inputs_pkg::player_bits_t game_coin,
    output arcade_inputs_pkg::player_bits_t game_start,
    output logic                            game_service,
    output logic                            game_pause,
    output arcade_inputs_pkg::gfx_en_t      gfx_en,
    output logic                            game_rst
);
    import arcade_inputs_pkg::*;

    player_bits_t sync_start;
    player_bits_t sync_coin;
    logic         pause_p1;
    logic         pause_p2;
    logic         soft_rst;

    joy_player #(.BUTTONS(BUTTONS), .ACTIVE_LOW(ACTIVE_LOW)) u_player1 (
        .clk_sys    ( clk_sys         ), .rst       ( rst           ),
        .en_4way    ( en_4way         ), .rotate    ( rotate        ),
        .flip       ( flip            ), .board_joy ( board_joystick1 ),
        .key_joy    ( key_joy1        ), .game_joy  ( game_joystick1  ),
        .sync_start ( sync_start[0]   ), .sync_coin ( sync_coin[0]  ),
        .sync_pause ( pause_p1        )
    );

    joy_player #(.BUTTONS(BUTTONS), .ACTIVE_LOW(ACTIVE_LOW)) u_player2 (
        .clk_sys    ( clk_sys         ), .rst       ( rst           ),
        .en_4way    ( en_4way         ), .rotate    ( rotate        ),
        .flip       ( flip            ), .board_joy ( board_joystick2 ),
        .key_joy    ( key_joy2        ), .game_joy  ( game_joystick2  ),
        .sync_start ( sync_start[1]   ), .sync_coin ( sync_coin[1]  ),
        .sync_pause ( pause_p2        )
    );

    // only players 1 and 2 can pause the game
    joy_player #(.BUTTONS(BUTTONS), .ACTIVE_LOW(ACTIVE_LOW)) u_player3 (
        .clk_sys    ( clk_sys         ), .rst       ( rst           ),
        .en_4way    ( en_4way         ), .rotate    ( rotate        ),
        .flip       ( flip            ), .board_joy ( board_joystick3 ),
        .key_joy    ( key_joy3        ), .game_joy  ( game_joystick3  ),
        .sync_start ( sync_start[2]   ), .sync_coin ( sync_coin[2]  ),
        .sync_pause (                 )
    );

    joy_player #(.BUTTONS(BUTTONS), .ACTIVE_LOW(ACTIVE_LOW)) u_player4 (
        .clk_sys    ( clk_sys         ), .rst       ( rst           ),
        .en_4way    ( en_4way         ), .rotate    ( rotate        ),
        .flip       ( flip            ), .board_joy ( board_joystick4 ),
        .key_joy    ( key_joy4        ), .game_joy  ( game_joystick4  ),
        .sync_start ( sync_start[3]   ), .sync_coin ( sync_coin[3]  ),
        .sync_pause (                 )
    );

    board_ctrl #(.ACTIVE_LOW(ACTIVE_LOW)) u_ctrl (
        .clk_sys      ( clk_sys             ),
        .rst          ( rst                 ),
        .sync_start   ( sync_start          ),
        .sync_coin    ( sync_coin           ),
        .joy_pause    ( pause_p1 | pause_p2 ),
        .key_start    ( key_start           ),
        .key_coin     ( key_coin            ),
        .key_pause    ( key_pause           ),
        .key_reset    ( key_reset           ),
        .key_service  ( key_service         ),
        .key_gfx      ( key_gfx             ),
        .osd_pause    ( osd_pause           ),
        .downloading  ( downloading         ),
        .game_coin    ( game_coin           ),
        .game_start   ( game_start          ),
        .game_service ( game_service        ),
        .game_pause   ( game_pause          ),
        .gfx_en       ( gfx_en              ),
        .soft_rst     ( soft_rst            )
    );

    game_reset #(.RST_HOLD(RST_HOLD)) u_game_rst (
        .clk_sys     ( clk_sys     ),
        .rst         ( rst         ),
        .rst_req     ( rst_req     ),
        .downloading ( downloading ),
        .soft_rst    ( soft_rst    ),
        .game_rst    ( game_rst    )
    );

endmodule

// ==== verilog/arcade_inputs_pkg.sv ====
// ----------------------------------------------------------------------
// arcade input section shared definitions
// widths, word types and direction bit positions used by the
// joystick, control and reset blocks
// ----------------------------------------------------------------------
package arcade_inputs_pkg;

    // word widths and counts
    localparam int JOY_BW     = 16;
    localparam int GAME_JW    = 10;
    localparam int PLAYERS    = 4;
    localparam int GFX_LAYERS = 4;

    // direction bits in the low nibble of every joystick word
    localparam int DIR_RIGHT = 0;
    localparam int DIR_LEFT  = 1;
    localparam int DIR_DOWN  = 2;
    localparam int DIR_UP    = 3;

    // first button bit; start, coin and pause follow the buttons
    localparam int BTN_BASE = 4;

    typedef logic [JOY_BW-1:0]     board_joy_t;
    typedef logic [GAME_JW-1:0]    game_joy_t;
    typedef logic [3:0]            dir_t;
    typedef logic [PLAYERS-1:0]    player_bits_t;
    typedef logic [GFX_LAYERS-1:0] gfx_en_t;

    // last axis seen by the 4-way filter
    typedef enum logic [1:0] {
        axis_none,
        axis_horiz,
        axis_vert
    } axis_e;

endpackage

// ==== verilog/board_ctrl.sv ====
// ----------------------------------------------------------------------
// board control keys
// coin, start and service outputs, pause toggle, soft reset pulse
// and graphics layer enables
// ----------------------------------------------------------------------
module board_ctrl #(
    parameter bit ACTIVE_LOW = 1'b1
) (
    input  logic                            clk_sys,
    input  logic                            rst,
    input  arcade_inputs_pkg::player_bits_t sync_start,
    input  arcade_inputs_pkg::player_bits_t sync_coin,
    input  logic                            joy_pause,
    input  arcade_inputs_pkg::player_bits_t key_start,
    input  arcade_inputs_pkg::player_bits_t key_coin,
    input  logic                            key_pause,
    input  logic                            key_reset,
    input  logic                            key_service,
    input  arcade_inputs_pkg::gfx_en_t      key_gfx,
    input  logic                            osd_pause,
    input  logic                            downloading,
    output arcade_inputs_pkg::player_bits_t game_coin,
    output arcade_inputs_pkg::player_bits_t game_start,
    output logic                            game_service,
    output logic                            game_pause,
    output arcade_inputs_pkg::gfx_en_t      gfx_en,
    output logic                            soft_rst
);
    import arcade_inputs_pkg::*;

    logic    last_key_pause;
    logic    last_joy_pause;
    logic    last_osd_pause;
    logic    last_key_reset;
    gfx_en_t last_gfx;

    // previous levels for edge detection
    always_ff @(posedge clk_sys) begin
        if (rst) begin
            last_key_pause <= 1'b0;
            last_joy_pause <= 1'b0;
            last_osd_pause <= 1'b0;
            last_key_reset <= 1'b0;
            last_gfx       <= '0;
        end else begin
            last_key_pause <= key_pause;
            last_joy_pause <= joy_pause;
            last_osd_pause <= osd_pause;
            last_key_reset <= key_reset;
            last_gfx       <= key_gfx;
        end
    end

    always_ff @(posedge clk_sys) begin
        if (rst) begin
            game_coin    <= {PLAYERS{ACTIVE_LOW}};
            game_start   <= {PLAYERS{ACTIVE_LOW}};
            game_service <= ACTIVE_LOW;
            game_pause   <= 1'b0;
            soft_rst     <= 1'b0;
            gfx_en       <= '1;
        end else begin
            game_coin    <= (sync_coin | key_coin) ^ {PLAYERS{ACTIVE_LOW}};
            game_start   <= (sync_start | key_start) ^ {PLAYERS{ACTIVE_LOW}};
            game_service <= key_service ^ ACTIVE_LOW;
            soft_rst     <= key_reset & ~last_key_reset;

            // download wins, then the menu, then the toggles
            if (downloading) begin
                game_pause <= 1'b0;
            end else if (osd_pause != last_osd_pause) begin
                game_pause <= osd_pause;
            end else if ((key_pause && !last_key_pause) ||
                         (joy_pause && !last_joy_pause)) begin
                game_pause <= ~game_pause;
            end

            for (int i = 0; i < GFX_LAYERS; i++) begin
                if (key_gfx[i] && !last_gfx[i]) begin
                    gfx_en[i] <= ~gfx_en[i];
                end
            end
        end
    end

endmodule

// ==== verilog/game_reset.sv ====
// ----------------------------------------------------------------------
// game reset stretcher
// holds the game in reset for a fixed time after the last request
// ----------------------------------------------------------------------
module game_reset #(
    parameter int RST_HOLD = 16
) (
    input  logic clk_sys,
    input  logic rst,
    input  logic rst_req,
    input  logic downloading,
    input  logic soft_rst,
    output logic game_rst
);

    localparam int CW = $clog2(RST_HOLD + 1);

    logic          req_any;
    logic [CW-1:0] hold_cnt;

    assign req_any = rst | rst_req | downloading | soft_rst;

    // reload while any source is active, then count out
    always_ff @(posedge clk_sys) begin
        if (req_any) begin
            hold_cnt <= CW'(RST_HOLD);
        end else if (hold_cnt != '0) begin
            hold_cnt <= hold_cnt - 1'b1;
        end
    end

    assign game_rst = req_any | (hold_cnt != '0);

endmodule

// ==== verilog/joy_4way.sv ====
// ----------------------------------------------------------------------
// 4-way joystick filter
// diagonals resolve to the axis that was pressed first
// ----------------------------------------------------------------------
module joy_4way (
    input  logic                    clk_sys,
    input  logic                    rst,
    input  logic                    enable,
    input  arcade_inputs_pkg::dir_t joy8,
    output arcade_inputs_pkg::dir_t joy4
);
    import arcade_inputs_pkg::*;

    axis_e axis;
    dir_t  horiz_bits;
    dir_t  vert_bits;
    logic  has_horiz;
    logic  has_vert;

    // split the nibble per axis
    always_comb begin
        horiz_bits = '0;
        vert_bits  = '0;
        horiz_bits[DIR_RIGHT] = joy8[DIR_RIGHT];
        horiz_bits[DIR_LEFT]  = joy8[DIR_LEFT];
        vert_bits[DIR_DOWN]   = joy8[DIR_DOWN];
        vert_bits[DIR_UP]     = joy8[DIR_UP];
        has_horiz = |horiz_bits;
        has_vert  = |vert_bits;
    end

    always_ff @(posedge clk_sys) begin
        if (rst) begin
            axis <= axis_none;
            joy4 <= '0;
        end else if (!enable) begin
            // plain register stage so latency stays the same
            axis <= axis_none;
            joy4 <= joy8;
        end else begin
            if (has_horiz && !has_vert) begin
                axis <= axis_horiz;
                joy4 <= horiz_bits;
            end else if (has_vert && !has_horiz) begin
                axis <= axis_vert;
                joy4 <= vert_bits;
            end else if (has_horiz && has_vert) begin
                // a diagonal keeps the remembered axis
                case (axis)
                    axis_horiz: joy4 <= horiz_bits;
                    axis_vert:  joy4 <= vert_bits;
                    default:    joy4 <= '0;
                endcase
            end else begin
                axis <= axis_none;
                joy4 <= '0;
            end
        end
    end

endmodule

// ==== verilog/joy_player.sv ====
// ----------------------------------------------------------------------
// single player joystick path
// sync, 4-way filter, keyboard merge, rotation and output polarity
// ----------------------------------------------------------------------
module joy_player #(
    parameter int BUTTONS    = 2,
    parameter bit ACTIVE_LOW = 1'b1
) (
    input  logic                          clk_sys,
    input  logic                          rst,
    input  logic                          en_4way,
    input  logic                          rotate,
    input  logic                          flip,
    input  arcade_inputs_pkg::board_joy_t board_joy,
    input  arcade_inputs_pkg::game_joy_t  key_joy,
    output arcade_inputs_pkg::game_joy_t  game_joy,
    output logic                          sync_start,
    output logic                          sync_coin,
    output logic                          sync_pause
);
    import arcade_inputs_pkg::*;

    localparam int START_BIT = BTN_BASE + BUTTONS;
    localparam int COIN_BIT  = BTN_BASE + BUTTONS + 1;
    localparam int PAUSE_BIT = BTN_BASE + BUTTONS + 2;

    dir_t       joy_filt;
    board_joy_t joy_sync;
    game_joy_t  merged;
    game_joy_t  rotated;

    joy_4way u_4way (
        .clk_sys ( clk_sys        ),
        .rst     ( rst            ),
        .enable  ( en_4way        ),
        .joy8    ( board_joy[3:0] ),
        .joy4    ( joy_filt       )
    );

    // directions come from the filter, one stage ahead of the buttons
    always_ff @(posedge clk_sys) begin
        if (rst) begin
            joy_sync <= '0;
        end else begin
            joy_sync <= {board_joy[JOY_BW-1:4], joy_filt};
        end
    end

    assign sync_start = joy_sync[START_BIT];
    assign sync_coin  = joy_sync[COIN_BIT];
    assign sync_pause = joy_sync[PAUSE_BIT];

    // keyboard merge and screen rotation
    always_comb begin
        merged  = joy_sync[GAME_JW-1:0] | key_joy;
        rotated = merged;
        if (rotate) begin
            if (flip) begin
                rotated[DIR_UP]    = merged[DIR_LEFT];
                rotated[DIR_DOWN]  = merged[DIR_RIGHT];
                rotated[DIR_LEFT]  = merged[DIR_DOWN];
                rotated[DIR_RIGHT] = merged[DIR_UP];
            end else begin
                rotated[DIR_UP]    = merged[DIR_RIGHT];
                rotated[DIR_DOWN]  = merged[DIR_LEFT];
                rotated[DIR_LEFT]  = merged[DIR_UP];
                rotated[DIR_RIGHT] = merged[DIR_DOWN];
            end
        end
    end

    // game side polarity
    always_ff @(posedge clk_sys) begin
        if (rst) begin
            game_joy <= {GAME_JW{ACTIVE_LOW}};
        end else begin
            game_joy <= rotated ^ {GAME_JW{ACTIVE_LOW}};
        end
    end

endmodule
